//--- build.f
+incdir+design
design/cache_addr_pkg.sv
design/cache_ctrl_pkg.sv
design/cache_ctrl_if.sv
design/cache_datapath.sv
design/cache_controller.sv
design/cache_top.sv
testbench/cache_tb.sv

//--- design/cache_addr_pkg.sv
`include "cache_settings.svh"

package cache_addr_pkg;

    typedef logic [`CACHE_ADDR_W-1:0]   addr_t;    // Byte address
    typedef logic [`CACHE_DATA_W-1:0]   word_t;    // Data word
    typedef logic [`CACHE_TAG_W-1:0]    tag_t;
    typedef logic [`CACHE_INDEX_W-1:0]  index_t;
    typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

    // One cache line with the data in the upper bits
    typedef struct packed {
        word_t data;
        tag_t  tag;
        logic  valid;
        logic  dirty;
    } line_t;

endpackage

//--- design/cache_controller.sv
`timescale 1ns/1ns

module cache_controller (
    input  logic       clk_i,
    input  logic       rst_i,

    // CPU request strobes
    input  logic       cpu_rd_i,
    input  logic       cpu_wr_i,
    input  logic       cpu_flush_i,
    output logic       cpu_done_o,
    output logic       cpu_hit_o,

    // Memory strobes
    input  logic       mem_ack_i,
    output logic       mem_rd_o,
    output logic       mem_wr_o,

    cache_ctrl_if.ctrl ctl
);

    cache_ctrl_pkg::ctrl_state_t state_q;
    cache_ctrl_pkg::ctrl_state_t state_d;

    logic req_wr_q;     // Pending request is a store
    logic hit_q;        // Outcome of the tag compare

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            state_q  <= cache_ctrl_pkg::IDLE;
            req_wr_q <= 1'b0;
            hit_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == cache_ctrl_pkg::IDLE &&
                (cpu_rd_i || cpu_wr_i || cpu_flush_i)) begin
                req_wr_q <= cpu_wr_i && !cpu_flush_i;
                hit_q    <= 1'b0;
            end
            if (state_q == cache_ctrl_pkg::COMPARE) begin
                hit_q <= ctl.hit;
            end
        end
    end

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            cache_ctrl_pkg::IDLE: begin
                if (cpu_flush_i) begin
                    state_d = cache_ctrl_pkg::FLUSH_CHECK;
                end else if (cpu_rd_i || cpu_wr_i) begin
                    state_d = cache_ctrl_pkg::COMPARE;
                end
            end
            cache_ctrl_pkg::COMPARE: begin
                if (ctl.hit) begin
                    state_d = cache_ctrl_pkg::DONE;
                end else if (ctl.dirty) begin
                    state_d = cache_ctrl_pkg::WRITE_BACK;
                end else begin
                    state_d = cache_ctrl_pkg::REFILL;
                end
            end
            cache_ctrl_pkg::WRITE_BACK: begin
                if (mem_ack_i) state_d = cache_ctrl_pkg::REFILL;
            end
            cache_ctrl_pkg::REFILL: begin
                if (mem_ack_i) state_d = cache_ctrl_pkg::DONE;
            end
            cache_ctrl_pkg::FLUSH_CHECK: begin
                if (ctl.flush_done) begin
                    state_d = cache_ctrl_pkg::DONE;
                end else if (ctl.dirty) begin
                    state_d = cache_ctrl_pkg::FLUSH_WRITE;
                end
            end
            cache_ctrl_pkg::FLUSH_WRITE: begin
                if (mem_ack_i) state_d = cache_ctrl_pkg::FLUSH_CHECK;
            end
            default: begin
                state_d = cache_ctrl_pkg::IDLE;     // DONE lasts one cycle
            end
        endcase
    end

    // Control outputs per state
    always_comb begin
        cpu_done_o      = 1'b0;
        mem_rd_o        = 1'b0;
        mem_wr_o        = 1'b0;
        ctl.fill_sel    = cache_ctrl_pkg::NONE;
        ctl.flush_en    = 1'b0;
        ctl.flush_step  = 1'b0;
        ctl.flush_clear = 1'b0;
        ctl.addr_sel_wb = 1'b0;
        case (state_q)
            cache_ctrl_pkg::WRITE_BACK: begin
                mem_wr_o        = 1'b1;
                ctl.addr_sel_wb = 1'b1;
            end
            cache_ctrl_pkg::REFILL: begin
                mem_rd_o = 1'b1;
                if (mem_ack_i) ctl.fill_sel = cache_ctrl_pkg::MEM;  // Data valid with ack
            end
            cache_ctrl_pkg::FLUSH_CHECK: begin
                ctl.flush_en = 1'b1;
                // Clean lines are dropped without a memory write
                if (!ctl.flush_done && !ctl.dirty) begin
                    ctl.flush_clear = 1'b1;
                    ctl.flush_step  = 1'b1;
                end
            end
            cache_ctrl_pkg::FLUSH_WRITE: begin
                ctl.flush_en    = 1'b1;
                ctl.addr_sel_wb = 1'b1;
                mem_wr_o        = 1'b1;
                if (mem_ack_i) begin
                    ctl.flush_clear = 1'b1;
                    ctl.flush_step  = 1'b1;
                end
            end
            cache_ctrl_pkg::DONE: begin
                cpu_done_o = 1'b1;
                // Store goes in after any refill has settled
                if (req_wr_q) ctl.fill_sel = cache_ctrl_pkg::CPU;
            end
            default: ;
        endcase
    end

    assign cpu_hit_o = hit_q;

    a_mem_strobes_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        !(mem_rd_o && mem_wr_o)
    ) else $error("Memory read and write strobes both high");

    a_done_pulse: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        cpu_done_o |=> !cpu_done_o
    ) else $error("cpu_done_o held longer than one cycle");

endmodule

//--- design/cache_ctrl_if.sv
`timescale 1ns/1ns

interface cache_ctrl_if;

    // Controller to datapath
    cache_ctrl_pkg::fill_sel_t fill_sel;
    logic flush_en;         // Counter picks the line
    logic flush_step;
    logic flush_clear;      // Invalidate counted line
    logic addr_sel_wb;      // Victim address to memory

    // Datapath to controller
    logic hit;
    logic dirty;
    logic flush_done;

    modport ctrl (
        output fill_sel,
        output flush_en,
        output flush_step,
        output flush_clear,
        output addr_sel_wb,
        input  hit,
        input  dirty,
        input  flush_done
    );

    modport dp (
        input  fill_sel,
        input  flush_en,
        input  flush_step,
        input  flush_clear,
        input  addr_sel_wb,
        output hit,
        output dirty,
        output flush_done
    );

endinterface

//--- design/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

    // Controller sequencing states
    typedef enum logic [2:0] {
        IDLE,
        COMPARE,
        WRITE_BACK,     // Dirty victim to memory
        REFILL,         // Line from memory
        FLUSH_CHECK,
        FLUSH_WRITE,
        DONE
    } ctrl_state_t;

    // Source of a line array write
    typedef enum logic [1:0] {
        NONE,
        CPU,
        MEM
    } fill_sel_t;

endpackage

//--- design/cache_datapath.sv
`timescale 1ns/1ns
`include "cache_settings.svh"

module cache_datapath (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // CPU side
    input  cache_addr_pkg::addr_t cpu_addr_i,
    input  cache_addr_pkg::word_t cpu_wdata_i,
    output cache_addr_pkg::word_t cpu_rdata_o,

    // Memory side
    input  cache_addr_pkg::word_t mem_rdata_i,
    output cache_addr_pkg::addr_t mem_addr_o,
    output cache_addr_pkg::word_t mem_wdata_o,

    cache_ctrl_if.dp              ctl
);

    localparam logic [`CACHE_CNT_W-1:0] LAST_CNT = `CACHE_LINES;

    cache_addr_pkg::line_t  lines [`CACHE_LINES];

    cache_addr_pkg::tag_t   req_tag;
    cache_addr_pkg::index_t req_index;
    cache_addr_pkg::index_t sel_idx;
    cache_addr_pkg::line_t  sel_line;
    cache_addr_pkg::addr_t  wb_addr;

    logic [`CACHE_CNT_W-1:0] flush_cnt;

    // Address decode
    assign req_tag   = cpu_addr_i[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign req_index = cpu_addr_i[`CACHE_OFFSET_W +: `CACHE_INDEX_W];

    // During a flush the counter walks the lines
    assign sel_idx  = ctl.flush_en ? flush_cnt[`CACHE_INDEX_W-1:0] : req_index;
    assign sel_line = lines[sel_idx];

    // Status back to the controller
    assign ctl.hit        = sel_line.valid && (sel_line.tag == req_tag);
    assign ctl.dirty      = sel_line.dirty;
    assign ctl.flush_done = (flush_cnt == LAST_CNT);

    // Word aligned victim address rebuilt from the stored tag
    assign wb_addr = {sel_line.tag, sel_idx, cache_addr_pkg::offset_t'('0)};

    assign cpu_rdata_o = sel_line.data;
    assign mem_wdata_o = sel_line.data;
    assign mem_addr_o  = ctl.addr_sel_wb ? wb_addr : cpu_addr_i;   // Refill uses request address

    // Line array writes
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            for (int i = 0; i < `CACHE_LINES; i++) begin
                lines[i] <= '0;
            end
        end else begin
            case (ctl.fill_sel)
                cache_ctrl_pkg::CPU: begin
                    lines[sel_idx].data  <= cpu_wdata_i;
                    lines[sel_idx].valid <= 1'b1;
                    lines[sel_idx].dirty <= 1'b1;   // Store makes the line dirty
                end
                cache_ctrl_pkg::MEM: begin
                    lines[sel_idx].data  <= mem_rdata_i;
                    lines[sel_idx].tag   <= req_tag;
                    lines[sel_idx].valid <= 1'b1;
                    lines[sel_idx].dirty <= 1'b0;   // Refilled line is clean
                end
                default: begin
                    if (ctl.flush_clear) begin
                        lines[sel_idx].valid <= 1'b0;
                        lines[sel_idx].dirty <= 1'b0;
                    end
                end
            endcase
        end
    end

    // Flush counter held at zero outside a flush
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            flush_cnt <= '0;
        end else if (!ctl.flush_en) begin
            flush_cnt <= '0;
        end else if (ctl.flush_step) begin
            flush_cnt <= flush_cnt + 1'b1;
        end
    end

    // A CPU store must not land on a line picked by the flush counter
    a_no_cpu_fill_in_flush: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        ctl.flush_en |-> (ctl.fill_sel != cache_ctrl_pkg::CPU)
    ) else $error("CPU line write during flush");

    // Controller must stop stepping once all lines are walked
    a_cnt_bound: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        (flush_cnt == LAST_CNT) |-> !ctl.flush_step
    ) else $error("Flush counter stepped past last line");

endmodule

//--- design/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Address and word widths
`define CACHE_ADDR_W    32
`define CACHE_DATA_W    32

// Line array geometry
`define CACHE_LINES     8
`define CACHE_INDEX_W   3
`define CACHE_OFFSET_W  2

// Address bits 31 down to 5
`define CACHE_TAG_W     27

// One bit above the index so the count can reach the line total
`define CACHE_CNT_W     4

`endif

//--- design/cache_top.sv
`timescale 1ns/1ns

module cache_top (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // CPU port
    input  logic                  cpu_rd_i,
    input  logic                  cpu_wr_i,
    input  logic                  cpu_flush_i,
    input  cache_addr_pkg::addr_t cpu_addr_i,
    input  cache_addr_pkg::word_t cpu_wdata_i,
    output cache_addr_pkg::word_t cpu_rdata_o,
    output logic                  cpu_done_o,
    output logic                  cpu_hit_o,

    // Main memory port
    output logic                  mem_rd_o,
    output logic                  mem_wr_o,
    output cache_addr_pkg::addr_t mem_addr_o,
    output cache_addr_pkg::word_t mem_wdata_o,
    input  logic                  mem_ack_i,
    input  cache_addr_pkg::word_t mem_rdata_i
);

    cache_ctrl_if ctl_if ();

    cache_controller cache_controller_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cpu_rd_i    (cpu_rd_i),
        .cpu_wr_i    (cpu_wr_i),
        .cpu_flush_i (cpu_flush_i),
        .cpu_done_o  (cpu_done_o),
        .cpu_hit_o   (cpu_hit_o),
        .mem_ack_i   (mem_ack_i),
        .mem_rd_o    (mem_rd_o),
        .mem_wr_o    (mem_wr_o),
        .ctl         (ctl_if.ctrl)
    );

    cache_datapath cache_datapath_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_wdata_i (cpu_wdata_i),
        .cpu_rdata_o (cpu_rdata_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .ctl         (ctl_if.dp)
    );

endmodule

//--- run.sh
#!/bin/sh
# Build the cache testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f build.f \
    && ./obj_dir/Vcache_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "TESTS PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- testbench/cache_tb.sv
`timescale 1ns/1ns
`include "cache_settings.svh"

module cache_tb;

    localparam int DONE_LIMIT = 200;    // Cycles allowed per request
    localparam int MEM_WORDS  = 64;

    logic                  clk_i = 1'b0;
    logic                  rst_i;
    logic                  cpu_rd_i;
    logic                  cpu_wr_i;
    logic                  cpu_flush_i;
    cache_addr_pkg::addr_t cpu_addr_i;
    cache_addr_pkg::word_t cpu_wdata_i;
    cache_addr_pkg::word_t cpu_rdata_o;
    logic                  cpu_done_o;
    logic                  cpu_hit_o;
    logic                  mem_rd_o;
    logic                  mem_wr_o;
    cache_addr_pkg::addr_t mem_addr_o;
    cache_addr_pkg::word_t mem_wdata_o;
    logic                  mem_ack_i;
    cache_addr_pkg::word_t mem_rdata_i;

    // Shadow of the cache lines and of main memory
    logic                  sh_valid [`CACHE_LINES];
    logic                  sh_dirty [`CACHE_LINES];
    cache_addr_pkg::tag_t  sh_tag   [`CACHE_LINES];
    cache_addr_pkg::word_t sh_data  [`CACHE_LINES];
    cache_addr_pkg::word_t sh_mem   [MEM_WORDS];
    cache_addr_pkg::word_t mem      [MEM_WORDS];   // Memory model storage

    // Expected and observed memory traffic
    cache_addr_pkg::addr_t exp_ra[$];
    cache_addr_pkg::addr_t exp_wa[$];
    cache_addr_pkg::word_t exp_wd[$];
    cache_addr_pkg::addr_t seen_ra[$];
    cache_addr_pkg::addr_t seen_wa[$];
    cache_addr_pkg::word_t seen_wd[$];

    int seed       = 95269;
    int mismatches = 0;
    int proto_errs = 0;
    int timeouts   = 0;

    always #4 clk_i = ~clk_i;

    cache_top cache_top_inst (.*);

    // Answers each strobe after 1 to 5 cycles with an ack pulse
    always begin : memory_model
        logic                  is_wr;
        cache_addr_pkg::addr_t a;
        cache_addr_pkg::word_t d;
        int                    delay;
        @(negedge clk_i);
        if (rst_i && (mem_rd_o || mem_wr_o)) begin
            is_wr = mem_wr_o;
            a     = mem_addr_o;
            d     = mem_wdata_o;
            delay = 1 + ({$random(seed)} % 5);
            repeat (delay) @(posedge clk_i);
            if (is_wr) begin
                mem[a[7:2]] = d;
                seen_wa.push_back(a);
                seen_wd.push_back(d);
            end else begin
                seen_ra.push_back(a);
                mem_rdata_i <= mem[a[7:2]];
            end
            mem_ack_i <= 1'b1;
            @(posedge clk_i);
            mem_ack_i <= 1'b0;
        end
    end

    // Write-back and write-allocate rules applied to the shadow state
    function automatic void predict_access(input logic wr, input cache_addr_pkg::addr_t a,
                                           input cache_addr_pkg::word_t wd,
                                           output logic hit, output cache_addr_pkg::word_t rd);
        cache_addr_pkg::index_t idx;
        cache_addr_pkg::tag_t   tg;
        cache_addr_pkg::addr_t  victim;
        idx = a[4:2];
        tg  = a[31:5];
        hit = sh_valid[idx] && (sh_tag[idx] == tg);
        if (!hit) begin
            if (sh_dirty[idx]) begin
                victim = {sh_tag[idx], idx, 2'b00};
                exp_wa.push_back(victim);
                exp_wd.push_back(sh_data[idx]);
                sh_mem[victim[7:2]] = sh_data[idx];
            end
            exp_ra.push_back(a);    // Refill uses the request address
            sh_tag[idx]   = tg;
            sh_data[idx]  = sh_mem[a[7:2]];
            sh_valid[idx] = 1'b1;
            sh_dirty[idx] = 1'b0;
        end
        rd = sh_data[idx];
        if (wr) begin
            sh_data[idx]  = wd;
            sh_dirty[idx] = 1'b1;
        end
    endfunction

    // Dirty lines leave in index order and every line is dropped
    function automatic void predict_flush();
        cache_addr_pkg::addr_t victim;
        for (int i = 0; i < `CACHE_LINES; i++) begin
            if (sh_dirty[i]) begin
                victim = {sh_tag[i], cache_addr_pkg::index_t'(i), 2'b00};
                exp_wa.push_back(victim);
                exp_wd.push_back(sh_data[i]);
                sh_mem[victim[7:2]] = sh_data[i];
            end
            sh_valid[i] = 1'b0;
            sh_dirty[i] = 1'b0;
        end
    endfunction

    task automatic check_word(input string name, input cache_addr_pkg::word_t exp,
                              input cache_addr_pkg::word_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_addr(input string name, input cache_addr_pkg::addr_t exp,
                              input cache_addr_pkg::addr_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_hit(input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: cpu_hit_o expected %b, got %b", $time, exp, act);
            mismatches++;
        end
    endtask

    // Compares and empties the traffic queues
    task automatic check_traffic();
        if (seen_ra.size() != exp_ra.size() || seen_wa.size() != exp_wa.size()) begin
            $display("ERROR at %0t: memory saw %0d reads and %0d writes, expected %0d and %0d",
                     $time, seen_ra.size(), seen_wa.size(), exp_ra.size(), exp_wa.size());
            proto_errs++;
        end else begin
            foreach (exp_ra[i]) check_addr("mem_addr_o on read", exp_ra[i], seen_ra[i]);
            foreach (exp_wa[i]) begin
                check_addr("mem_addr_o on write", exp_wa[i], seen_wa[i]);
                check_word("mem_wdata_o", exp_wd[i], seen_wd[i]);
            end
        end
        exp_ra.delete();
        exp_wa.delete();
        exp_wd.delete();
        seen_ra.delete();
        seen_wa.delete();
        seen_wd.delete();
    endtask

    // Drops the strobes and polls cpu_done_o at the falling edge
    task automatic wait_done(output int cycles);
        cycles = 0;
        do begin
            @(posedge clk_i);
            cpu_rd_i    <= 1'b0;
            cpu_wr_i    <= 1'b0;
            cpu_flush_i <= 1'b0;
            cycles++;
            @(negedge clk_i);
        end while (!cpu_done_o && cycles < DONE_LIMIT);
        if (!cpu_done_o) begin
            $display("ERROR at %0t: cpu_done_o did not arrive within %0d cycles",
                     $time, DONE_LIMIT);
            timeouts++;
        end
    endtask

    task automatic do_access(input logic wr, input cache_addr_pkg::addr_t a,
                             input cache_addr_pkg::word_t wd);
        logic                  exp_hit;
        cache_addr_pkg::word_t exp_rd;
        int                    cycles;
        predict_access(wr, a, wd, exp_hit, exp_rd);
        @(posedge clk_i);
        cpu_rd_i    <= !wr;
        cpu_wr_i    <= wr;
        cpu_addr_i  <= a;
        cpu_wdata_i <= wd;
        wait_done(cycles);
        if (cpu_done_o) begin
            check_hit(exp_hit, cpu_hit_o);
            if (!wr) check_word("cpu_rdata_o", exp_rd, cpu_rdata_o);
            if (exp_hit && cycles != 2) begin
                $display("ERROR at %0t: hit finished %0d cycles after the strobe, not 2",
                         $time, cycles);
                proto_errs++;
            end
        end
        check_traffic();
    endtask

    task automatic do_flush();
        int cycles;
        predict_flush();
        @(posedge clk_i);
        cpu_flush_i <= 1'b1;
        wait_done(cycles);
        check_traffic();
    endtask

    initial begin : stimulus
        logic [31:0] r;
        rst_i       = 1'b0;
        cpu_rd_i    = 1'b0;
        cpu_wr_i    = 1'b0;
        cpu_flush_i = 1'b0;
        cpu_addr_i  = '0;
        cpu_wdata_i = '0;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]    = 32'hC0DE_0000 + 32'(i * 4);     // Word holds its byte address
            sh_mem[i] = mem[i];
        end
        for (int i = 0; i < `CACHE_LINES; i++) begin
            sh_valid[i] = 1'b0;
            sh_dirty[i] = 1'b0;
            sh_tag[i]   = '0;
            sh_data[i]  = '0;
        end
        repeat (10) @(posedge clk_i);
        rst_i <= 1'b1;

        do_access(1'b0, 32'h0000_0024, '0);             // Cold miss
        do_access(1'b0, 32'h0000_0024, '0);
        do_access(1'b1, 32'h0000_0024, 32'hDEAD_BEEF);  // Write hit
        do_access(1'b0, 32'h0000_0024, '0);
        do_access(1'b0, 32'h0000_0064, '0);             // Same index evicts the dirty line
        do_access(1'b1, 32'h0000_0008, 32'h1234_5678);  // Write miss
        do_access(1'b0, 32'h0000_0008, '0);

        // Four tags only so conflicts and evictions are frequent
        repeat (60) begin
            r = $random(seed);
            do_access(r[7], cache_addr_pkg::addr_t'(r[6:0]), $random(seed));
        end

        do_flush();
        for (int i = 0; i < `CACHE_LINES; i++) begin
            do_access(1'b0, cache_addr_pkg::addr_t'(32 + i * 4), '0);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_word($sformatf("mem[%0d]", i), sh_mem[i], mem[i]);
        end

        $display("Errors: %0d mismatches, %0d traffic or timing errors, %0d timeouts",
                 mismatches, proto_errs, timeouts);
        if (mismatches == 0 && proto_errs == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
